// File: design/mipsPkg.sv
// shared types for the single-cycle MIPS core
// supported: add sub and or slt addi lw sw beq j jal, nothing else
// no delay slot, so jal links PC+4
// data address width is a module parameter of the core, not defined here

package mipsPkg;

  // ====================================================================
  // instruction word views
  // ====================================================================

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } rFieldsT;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm16;
  } iFieldsT;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target26;
  } jFieldsT;

  // one 32-bit word, decoded three ways
  typedef union packed {
    rFieldsT rType;
    iFieldsT iType;
    jFieldsT jType;
  } instrWord;

  // opcodes
  localparam logic [5:0] opR    = 6'h00;
  localparam logic [5:0] opJ    = 6'h02;
  localparam logic [5:0] opJal  = 6'h03;
  localparam logic [5:0] opBeq  = 6'h04;
  localparam logic [5:0] opAddi = 6'h08;
  localparam logic [5:0] opLw   = 6'h23;
  localparam logic [5:0] opSw   = 6'h2b;

  // funct codes, R-type only
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnSlt = 6'h2a;

  // ====================================================================
  // control and port bundles
  // ====================================================================

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt
  } aluOpE;

  // decoded controls, 47 bits
  typedef struct packed {
    aluOpE       aluOp;
    logic        useImm;
    logic        memToReg;
    logic        memWrite;
    logic        branch;
    logic        jump;
    logic        link;
    logic        regWrite;
    logic [4:0]  destReg;
    logic [31:0] imm;
  } ctrlT;

  // data memory request, word address
  typedef struct packed {
    logic        write;
    logic [29:0] addr;
    logic [31:0] wdata;
  } dmemReqT;

  // register writeback strobe
  typedef struct packed {
    logic        en;
    logic [4:0]  addr;
    logic [31:0] data;
  } wbT;

endpackage

// File: design/aluUnit.sv
// 32-bit ALU for the five supported operations
// no overflow detection, add and sub wrap

`timescale 1ns/10ps

module aluUnit (
  input  logic           [31:0] a,
  input  logic           [31:0] b,
  input  mipsPkg::aluOpE        op,
  output logic           [31:0] result,
  output logic                  zero
);
  import mipsPkg::*;

  always_comb begin
    case (op)
      aluAdd:  result = a + b;
      aluSub:  result = a - b;
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      // signed compare, result is 0 or 1
      aluSlt:  result = {31'd0, $signed(a) < $signed(b)};
      default: result = 32'd0;
    endcase
  end

  // used by beq after a subtract
  assign zero = (result == 32'd0);

endmodule

// File: design/fetchUnit.sv
// program counter, the only registered stage of the core
// jump wins over a taken branch, no delay slot

`timescale 1ns/10ps

module fetchUnit (
  input  logic        clk,
  input  logic        rst,
  input  logic        branchTaken,
  input  logic        jump,
  input  logic [31:0] imm,
  input  logic [25:0] target,
  output logic [31:0] pc,
  output logic [31:0] pcPlus4
);

  logic [31:0] pcNext;
  logic [31:0] jumpAddr;
  logic [31:0] branchAddr;

  assign pcPlus4 = pc + 32'd4;

  // region bits from pc+4, word target below
  assign jumpAddr = {pcPlus4[31:28], target, 2'b00};

  // offset counts words relative to pc+4
  assign branchAddr = pcPlus4 + {imm[29:0], 2'b00};

  always_comb begin
    if (jump) begin
      pcNext = jumpAddr;
    end else if (branchTaken) begin
      pcNext = branchAddr;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // fetch starts at address 0 after reset
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= 32'd0;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

// File: design/mainDecoder.sv
// opcode and funct decode, also does the ALU control job
// unknown opcodes and functs decode to a no-op with no writes
// write strobes are low while rst is low

`timescale 1ns/10ps

module mainDecoder (
  input  logic              rst,
  input  mipsPkg::instrWord instr,
  output mipsPkg::ctrlT     ctrl
);
  import mipsPkg::*;

  logic       wrReq;
  logic       memReq;
  logic [4:0] dest;

  always_comb begin
    ctrl        = '0;
    ctrl.aluOp  = aluAdd;
    // sign extend for addi, lw, sw and beq
    ctrl.imm    = {{16{instr.iType.imm16[15]}}, instr.iType.imm16};
    wrReq       = 1'b0;
    memReq      = 1'b0;
    dest        = 5'd0;

    case (instr.rType.opcode)
      opR: begin
        dest  = instr.rType.rd;
        wrReq = 1'b1;
        case (instr.rType.funct)
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          // unknown funct, nothing written
          default: wrReq = 1'b0;
        endcase
      end
      opAddi: begin
        ctrl.useImm = 1'b1;
        dest        = instr.iType.rt;
        wrReq       = 1'b1;
      end
      opLw: begin
        ctrl.useImm   = 1'b1;
        ctrl.memToReg = 1'b1;
        dest          = instr.iType.rt;
        wrReq         = 1'b1;
      end
      opSw: begin
        // address is base plus offset
        ctrl.useImm = 1'b1;
        memReq      = 1'b1;
      end
      opBeq: begin
        // compare by subtraction, zero flag decides
        ctrl.aluOp  = aluSub;
        ctrl.branch = 1'b1;
      end
      opJ: begin
        ctrl.jump = 1'b1;
      end
      opJal: begin
        ctrl.jump = 1'b1;
        ctrl.link = 1'b1;
        dest      = 5'd31;
        wrReq     = 1'b1;
      end
      default: begin
        // not supported, plain no-op
        wrReq = 1'b0;
      end
    endcase

    ctrl.destReg  = dest;
    // register 0 is never written
    ctrl.regWrite = wrReq & rst & (dest != 5'd0);
    ctrl.memWrite = memReq & rst;
  end

endmodule

// File: design/regFile.sv
// 32 x 32 register file, two combinational reads, one write per clock
// register 0 always reads as zero
// all registers clear on reset

`timescale 1ns/10ps

module regFile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rdAddr1,
  input  logic [4:0]  rdAddr2,
  output logic [31:0] rdData1,
  output logic [31:0] rdData2,
  input  mipsPkg::wbT wb
);

  logic [31:0] regs [32];

  // ====================================================================
  // write port
  // ====================================================================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (wb.en) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // ====================================================================
  // read ports
  // ====================================================================

  // no bypass, a write shows up on the next cycle's read
  assign rdData1 = (rdAddr1 == 5'd0) ? 32'd0 : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == 5'd0) ? 32'd0 : regs[rdAddr2];

endmodule

// File: design/execStage.sv
// operand select, ALU, branch test, data request and writeback select
// the data address is the ALU result in words, cut to dAddrBits
// dAddrBits must be between 1 and 30

`timescale 1ns/10ps

module execStage #(
  parameter int dAddrBits = 8
) (
  input  mipsPkg::ctrlT    ctrl,
  input  logic [31:0]      rdData1,
  input  logic [31:0]      rdData2,
  input  logic [31:0]      pcPlus4,
  input  logic [31:0]      memRdata,
  output mipsPkg::dmemReqT dmemReq,
  output mipsPkg::wbT      wb,
  output logic             branchTaken
);

  logic [31:0] opB;
  logic [31:0] aluResult;
  logic        aluZero;

  // immediate for addi, lw and sw
  assign opB = ctrl.useImm ? ctrl.imm : rdData2;

  aluUnit alu0 (
    .a      (rdData1),
    .b      (opB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // beq taken on equal operands
  assign branchTaken = ctrl.branch & aluZero;

  // byte offset bits dropped, upper bits tied low
  assign dmemReq.write = ctrl.memWrite;
  assign dmemReq.addr  = 30'(aluResult[dAddrBits+1:2]);
  assign dmemReq.wdata = rdData2;

  assign wb.en   = ctrl.regWrite;
  assign wb.addr = ctrl.destReg;

  // load data, link address or ALU result
  always_comb begin
    if (ctrl.memToReg) begin
      wb.data = memRdata;
    end else if (ctrl.link) begin
      wb.data = pcPlus4;
    end else begin
      wb.data = aluResult;
    end
  end

endmodule

// File: design/mipsCore.sv
// single-cycle MIPS core, one instruction per clock
// instruction and data memories are external and must answer combinationally
// dAddrBits sets the data word-address width, keep it at 30 or below
// no stalls, no back-pressure, no exceptions

`timescale 1ns/10ps

module mipsCore #(
  parameter int dAddrBits = 8
) (
  input  logic              clk,
  input  logic              rst,
  output logic [31:0]       instrAddr,
  input  mipsPkg::instrWord instr,
  output mipsPkg::dmemReqT  dmemReq,
  input  logic [31:0]       memRdata,
  output mipsPkg::wbT       wb
);
  import mipsPkg::*;

  ctrlT        ctrl;
  logic [31:0] rdData1;
  logic [31:0] rdData2;
  logic [31:0] pcPlus4;
  logic        branchTaken;

  // pc register and next address
  fetchUnit fetch0 (
    .clk         (clk),
    .rst         (rst),
    .branchTaken (branchTaken),
    .jump        (ctrl.jump),
    .imm         (ctrl.imm),
    .target      (instr.jType.target26),
    .pc          (instrAddr),
    .pcPlus4     (pcPlus4)
  );

  mainDecoder dec0 (
    .rst   (rst),
    .instr (instr),
    .ctrl  (ctrl)
  );

  // rs and rt read ports, write from the writeback strobe
  regFile rf0 (
    .clk     (clk),
    .rst     (rst),
    .rdAddr1 (instr.rType.rs),
    .rdAddr2 (instr.rType.rt),
    .rdData1 (rdData1),
    .rdData2 (rdData2),
    .wb      (wb)
  );

  execStage #(.dAddrBits(dAddrBits)) exec0 (
    .ctrl        (ctrl),
    .rdData1     (rdData1),
    .rdData2     (rdData2),
    .pcPlus4     (pcPlus4),
    .memRdata    (memRdata),
    .dmemReq     (dmemReq),
    .wb          (wb),
    .branchTaken (branchTaken)
  );

endmodule

// File: bench/mipsCoreTb.sv
// directed testbench for the single-cycle MIPS core, dAddrBits fixed at 8
// instruction ROM and data RAM hold 256 words each, programs start at address 0
// outputs are sampled at the falling edge, inputs change 5 ns after the rising edge

`timescale 1ns/10ps

module mipsCoreTb;
  import mipsPkg::*;

  // test length, used by the watchdog
  localparam int numTests    = 6;
  localparam int resetCycles = 6;
  localparam int stepCount   = 34;
  localparam int marginCycles = 50;
  localparam int watchCycles = numTests * resetCycles + stepCount + marginCycles;

  logic        clk;
  logic        rst;
  logic [31:0] instrAddr;
  instrWord    instr;
  dmemReqT     dmemReq;
  logic [31:0] memRdata;
  wbT          wb;

  instrWord    imem [256];
  logic [31:0] dmem [256];
  // reference model state
  logic [31:0] refMem [256];
  logic [31:0] refRegs [32];
  logic [31:0] refPc;
  int          checkCount = 0;
  int          errCount = 0;
  logic [31:0] lfsrState = 32'ha6b80c04;

  mipsCore #(.dAddrBits(8)) dut0 (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dmemReq   (dmemReq),
    .memRdata  (memRdata),
    .wb        (wb)
  );

  // ====================================================================
  // clock and memory models
  // ====================================================================

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // both memories answer combinationally
  assign instr    = imem[instrAddr[9:2]];
  assign memRdata = dmem[dmemReq.addr[7:0]];

  always @(posedge clk) begin
    if (dmemReq.write) begin
      dmem[dmemReq.addr[7:0]] <= dmemReq.wdata;
    end
  end

  // ====================================================================
  // helpers
  // ====================================================================

  // galois form, shift right, taps 32 30 26 25
  function automatic logic lfsrBit();
    logic out;
    out = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (out) begin
      lfsrState = lfsrState ^ 32'ha3000000;
    end
    return out;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrBit()};
    end
    return v;
  endfunction

  // small assembler
  function automatic instrWord rIns(input logic [5:0] fn, input logic [4:0] rd,
                                    input logic [4:0] rs, input logic [4:0] rt);
    instrWord w;
    w.rType = '{opcode: opR, rs: rs, rt: rt, rd: rd, shamt: 5'd0, funct: fn};
    return w;
  endfunction

  function automatic instrWord iIns(input logic [5:0] op, input logic [4:0] rt,
                                    input logic [4:0] rs, input logic [15:0] imm);
    instrWord w;
    w.iType = '{opcode: op, rs: rs, rt: rt, imm16: imm};
    return w;
  endfunction

  function automatic instrWord jIns(input logic [5:0] op, input logic [25:0] target);
    instrWord w;
    w.jType = '{opcode: op, target26: target};
    return w;
  endfunction

  function automatic logic [31:0] signExt(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    assert (got === exp) else begin
      errCount++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ====================================================================
  // reset and model step
  // ====================================================================

  // core held in reset, ROM cleared to no-ops for the next program
  task automatic enterReset();
    @(posedge clk);
    #5 rst = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
  endtask

  task automatic leaveReset();
    refPc = 32'd0;
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = 32'd0;
    end
    repeat (4) begin
      @(negedge clk);
      checkEq("instrAddr in reset", instrAddr, 32'd0);
      checkEq("wb.en in reset", 32'(wb.en), 32'd0);
      checkEq("dmemReq.write in reset", 32'(dmemReq.write), 32'd0);
    end
    @(posedge clk);
    #5 rst = 1'b1;
    @(negedge clk);
  endtask

  // checks one instruction against the ISA rules, then moves to the next sample point
  task automatic runStep();
    instrWord    w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sImm;
    logic [31:0] pc4;
    logic [31:0] nextPc;
    logic [31:0] byteAddr;
    logic [31:0] res;
    logic        expEn;
    logic        expWr;
    logic [4:0]  dest;
    w        = imem[refPc[9:2]];
    a        = refRegs[w.iType.rs];
    b        = refRegs[w.iType.rt];
    sImm     = signExt(w.iType.imm16);
    pc4      = refPc + 32'd4;
    nextPc   = pc4;
    byteAddr = a + sImm;
    res      = 32'd0;
    expEn    = 1'b0;
    expWr    = 1'b0;
    dest     = 5'd0;
    case (w.rType.opcode)
      opR: begin
        dest  = w.rType.rd;
        expEn = 1'b1;
        case (w.rType.funct)
          fnAdd:   res = a + b;
          fnSub:   res = a - b;
          fnAnd:   res = a & b;
          fnOr:    res = a | b;
          fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: expEn = 1'b0;
        endcase
      end
      opAddi: begin
        dest  = w.iType.rt;
        expEn = 1'b1;
        res   = byteAddr;
      end
      opLw: begin
        dest  = w.iType.rt;
        expEn = 1'b1;
        res   = refMem[byteAddr[9:2]];
      end
      opSw:  expWr = 1'b1;
      opBeq: nextPc = (a == b) ? pc4 + (sImm << 2) : pc4;
      opJ:   nextPc = {pc4[31:28], w.jType.target26, 2'b00};
      opJal: begin
        nextPc = {pc4[31:28], w.jType.target26, 2'b00};
        dest   = 5'd31;
        expEn  = 1'b1;
        res    = pc4;
      end
      default: expEn = 1'b0;
    endcase
    // register 0 never takes a write
    if (dest == 5'd0) begin
      expEn = 1'b0;
    end
    checkEq("instrAddr", instrAddr, refPc);
    checkEq("wb.en", 32'(wb.en), 32'(expEn));
    if (expEn) begin
      checkEq("wb.addr", 32'(wb.addr), 32'(dest));
      checkEq("wb.data", wb.data, res);
      refRegs[dest] = res;
    end
    checkEq("dmemReq.write", 32'(dmemReq.write), 32'(expWr));
    if (expWr) begin
      checkEq("dmemReq.addr", 32'(dmemReq.addr), {24'd0, byteAddr[9:2]});
      checkEq("dmemReq.wdata", dmemReq.wdata, b);
      refMem[byteAddr[9:2]] = b;
    end
    refPc = nextPc;
    @(negedge clk);
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================

  task automatic testReset();
    enterReset();
    // store at address 0, its strobe must stay low while in reset
    imem[0] = iIns(opSw, 5'd0, 5'd0, 16'd0);
    for (int i = 1; i < 6; i++) begin
      imem[i] = iIns(opAddi, 5'(i + 1), 5'd0, 16'(i * 3 + 1));
    end
    leaveReset();
    // straight line, pc steps by one word
    for (int i = 0; i < 6; i++) begin
      checkEq("sequential instrAddr", instrAddr, 32'(i * 4));
      runStep();
    end
  endtask

  task automatic testArith();
    logic [15:0] v1;
    logic [15:0] v2;
    logic [15:0] v3;
    v1 = 16'(randBits(16));
    // forced negative
    v2 = 16'(randBits(16)) | 16'h8000;
    v3 = 16'(randBits(16));
    enterReset();
    imem[0] = iIns(opAddi, 5'd1, 5'd0, v1);
    imem[1] = iIns(opAddi, 5'd2, 5'd0, v2);
    imem[2] = iIns(opAddi, 5'd3, 5'd0, v3);
    imem[3] = rIns(fnAdd, 5'd4, 5'd1, 5'd2);
    imem[4] = rIns(fnSub, 5'd5, 5'd1, 5'd2);
    imem[5] = rIns(fnAnd, 5'd6, 5'd2, 5'd3);
    imem[6] = rIns(fnOr, 5'd7, 5'd1, 5'd3);
    imem[7] = rIns(fnSlt, 5'd8, 5'd2, 5'd1);
    imem[8] = rIns(fnSlt, 5'd9, 5'd1, 5'd2);
    imem[9] = rIns(fnSub, 5'd10, 5'd2, 5'd4);
    leaveReset();
    repeat (10) runStep();
  endtask

  task automatic testZeroReg();
    logic [15:0] v;
    v = 16'(randBits(16));
    enterReset();
    imem[0] = iIns(opAddi, 5'd1, 5'd0, v);
    imem[1] = iIns(opAddi, 5'd0, 5'd0, 16'(randBits(16)));
    imem[2] = rIns(fnAdd, 5'd0, 5'd1, 5'd1);
    imem[3] = rIns(fnAdd, 5'd3, 5'd0, 5'd1);
    leaveReset();
    runStep();
    checkEq("wb.en for addi to r0", 32'(wb.en), 32'd0);
    runStep();
    checkEq("wb.en for add to r0", 32'(wb.en), 32'd0);
    runStep();
    checkEq("add through r0", wb.data, signExt(v));
    runStep();
  endtask

  task automatic testMem();
    logic [15:0] base;
    logic [15:0] v;
    base = 16'((randBits(6) + 1) << 2);
    v    = 16'(randBits(16));
    enterReset();
    imem[0] = iIns(opAddi, 5'd1, 5'd0, base);
    imem[1] = iIns(opAddi, 5'd2, 5'd0, v);
    imem[2] = iIns(opSw, 5'd2, 5'd1, 16'd8);
    imem[3] = iIns(opLw, 5'd3, 5'd1, 16'd8);
    imem[4] = iIns(opSw, 5'd3, 5'd1, 16'hfffc);
    imem[5] = iIns(opLw, 5'd4, 5'd1, 16'hfffc);
    leaveReset();
    runStep();
    runStep();
    checkEq("sw strobe", 32'(dmemReq.write), 32'd1);
    checkEq("sw word address", 32'(dmemReq.addr), 32'((base + 16'd8) >> 2));
    runStep();
    checkEq("lw data", wb.data, signExt(v));
    runStep();
    runStep();
    runStep();
  endtask

  task automatic testBranch();
    logic [15:0] v;
    v = 16'(randBits(16)) | 16'h0001;
    enterReset();
    imem[0] = iIns(opAddi, 5'd1, 5'd0, v);
    imem[1] = iIns(opAddi, 5'd2, 5'd0, v);
    imem[2] = iIns(opBeq, 5'd2, 5'd1, 16'd2);
    imem[3] = iIns(opAddi, 5'd3, 5'd0, 16'd1);
    imem[4] = iIns(opAddi, 5'd3, 5'd0, 16'd2);
    imem[5] = iIns(opBeq, 5'd0, 5'd1, 16'd5);
    imem[6] = iIns(opAddi, 5'd4, 5'd0, 16'd3);
    leaveReset();
    runStep();
    runStep();
    checkEq("wb.en on beq", 32'(wb.en), 32'd0);
    runStep();
    // taken, two words skipped
    checkEq("taken branch target", instrAddr, 32'd20);
    checkEq("wb.en on beq", 32'(wb.en), 32'd0);
    runStep();
    checkEq("branch fall through", instrAddr, 32'd24);
    runStep();
  endtask

  task automatic testJump();
    enterReset();
    imem[0] = jIns(opJ, 26'd4);
    imem[1] = iIns(opAddi, 5'd6, 5'd0, 16'd1);
    imem[4] = jIns(opJal, 26'd8);
    imem[5] = iIns(opAddi, 5'd6, 5'd0, 16'd2);
    imem[8] = rIns(fnAdd, 5'd5, 5'd31, 5'd0);
    leaveReset();
    runStep();
    checkEq("j target", instrAddr, 32'd16);
    checkEq("jal wb.en", 32'(wb.en), 32'd1);
    checkEq("jal wb.addr", 32'(wb.addr), 32'd31);
    checkEq("jal link", wb.data, 32'd20);
    runStep();
    checkEq("jal target", instrAddr, 32'd32);
    runStep();
  endtask

  // ====================================================================
  // main sequence and watchdog
  // ====================================================================

  initial begin
    rst = 1'b0;
    for (int i = 0; i < 256; i++) begin
      imem[i]   = '0;
      dmem[i]   = 32'h5a3c0000 + i * 32'h01010101;
      refMem[i] = 32'h5a3c0000 + i * 32'h01010101;
    end
    testReset();
    testArith();
    testZeroReg();
    testMem();
    testBranch();
    testJump();
    $display("%0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(watchCycles * 100);
    $display("timeout: tests did not finish within %0d cycles", watchCycles);
    $display("Errors found");
    $finish;
  end

endmodule

// File: mipsCore.f
design/mipsPkg.sv
design/aluUnit.sv
design/fetchUnit.sv
design/mainDecoder.sv
design/regFile.sv
design/execStage.sv
design/mipsCore.sv
bench/mipsCoreTb.sv

// File: Bender.yml
package:
  name: mipsCore

sources:
  # package first, then leaf modules, then the top level
  - files:
      - design/mipsPkg.sv
      - design/aluUnit.sv
      - design/fetchUnit.sv
      - design/mainDecoder.sv
      - design/regFile.sv
      - design/execStage.sv
      - design/mipsCore.sv

  # testbench, only for simulation
  - target: simulation
    files:
      - bench/mipsCoreTb.sv
